//--- fetch_stage.f
fetch_pkg.sv
fetch_pc.sv
fetch_ctrl.sv
fetch_buffer.sv
fetch_regfile.sv
fetch_stage.sv
fetch_imem_model.sv
fetch_stage_properties.sv
tb_fetch_stage.sv

//--- Makefile
# Verilator build for the fetch stage

VERILATOR  ?= verilator
TOP        := tb_fetch_stage
RTL_TOP    := fetch_stage
FILELIST   := fetch_stage.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fetch_stage.sv
////////////////////////////////////////////////////////////
// five tests of 256 transfers each with a reset before each
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_fetch_stage;

  localparam int CLK_PERIOD  = 4;
  localparam int XFERS       = 256;
  localparam int TEST_COUNT  = 5;
  localparam int WATCHDOG_NS = 4 * XFERS * TEST_COUNT * 6 * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  fetch_pkg::addr_t      instr_addr;
  logic                  instr_req;
  fetch_pkg::word_t      instr_data;
  logic                  instr_ack;
  logic [2:0]            ack_delay;
  fetch_pkg::fetch_out_t fetch;
  logic                  fetch_vld;
  logic                  fetch_rdy;
  logic                  branch;
  fetch_pkg::addr_t      branch_target;
  fetch_pkg::word_t      regrd_rs1;
  fetch_pkg::word_t      regrd_rs2;
  logic                  regwr_en;
  fetch_pkg::reg_idx_t   regwr_sel;
  fetch_pkg::word_t      regwr_data;

  logic [31:0] rng;
  logic [31:0] exp_pc;
  logic [31:0] shadow [32];
  int          xfer_count;
  int          stall_left;
  int          checks;
  int          err_count;
  int          fail_total;

  fetch_stage dut0 (.*);

  fetch_imem_model imem0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr_addr(instr_addr),
    .ack_delay (ack_delay),
    .instr_ack (instr_ack),
    .instr_data(instr_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected instruction word at an address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] x;
    x = addr ^ 32'h6a09_e667;
    x = x * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    x = x * 32'h85eb_ca6b;
    x = x ^ (x >> 13);
    return x;
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("mismatch %s: got %h expected %h", sig, got, want);
    err_count++;
  endtask

  task automatic check_transfer();
    logic [31:0] exp_ir;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    exp_ir = mem_word(exp_pc);
    rs1    = exp_ir[19:15];
    rs2    = exp_ir[24:20];
    checks += 4;
    assert (fetch.pc == exp_pc)
      else report_mismatch("fetch.pc", fetch.pc, exp_pc);
    assert (fetch.ir == exp_ir)
      else report_mismatch("fetch.ir", fetch.ir, exp_ir);
    assert (regrd_rs1 == shadow[rs1])
      else report_mismatch("regrd_rs1", regrd_rs1, shadow[rs1]);
    assert (regrd_rs2 == shadow[rs2])
      else report_mismatch("regrd_rs2", regrd_rs2, shadow[rs2]);
  endtask

  // outputs sampled at the rising edge before any register updates
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc     = 32'h0;
      xfer_count = 0;
      for (int i = 0; i < 32; i++) begin
        shadow[i] = 32'h0;
      end
    end else begin
      if (fetch_vld && fetch_rdy) begin
        check_transfer();
        exp_pc = exp_pc + 32'd4;
        xfer_count++;
      end
      if (branch) begin
        exp_pc = branch_target;
      end
      // a write is seen by reads from the next cycle on
      if (regwr_en && (regwr_sel != 5'd0)) begin
        shadow[regwr_sel] = regwr_data;
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst_n     = 1'b0;
    fetch_rdy = 1'b0;
    branch    = 1'b0;
    regwr_en  = 1'b0;
    ack_delay = 3'd0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic drive_cycle(input bit rdy_rand, input bit stall_rand,
                             input bit br_rand, input bit wr_rand);
    rng = xorshift32(rng);
    // decode drops ready for 1 to 4 cycles at a time
    if (!rdy_rand) begin
      fetch_rdy = 1'b1;
    end else if (stall_left > 0) begin
      fetch_rdy = 1'b0;
      stall_left--;
    end else if (rng[1:0] == 2'd0) begin
      fetch_rdy  = 1'b0;
      stall_left = int'(rng[3:2]);
    end else begin
      fetch_rdy = 1'b1;
    end
    ack_delay = stall_rand ? (rng[6:4] % 3'd5) : 3'd0;
    if (br_rand && !branch && (rng[11:8] == 4'd0)) begin
      branch        = 1'b1;
      branch_target = {18'h0, rng[25:14], 2'b00};
    end else begin
      branch = 1'b0;
    end
    regwr_en  = wr_rand && rng[12];
    regwr_sel = rng[31:27];
    rng        = xorshift32(rng);
    regwr_data = rng;
  endtask

  task automatic run_test(input int num, input string name, input bit rdy_rand,
                          input bit stall_rand, input bit br_rand, input bit wr_rand);
    int err_before;
    err_before = err_count;
    stall_left = 0;
    apply_reset();
    while (xfer_count < XFERS) begin
      drive_cycle(rdy_rand, stall_rand, br_rand, wr_rand);
      @(negedge clk);
    end
    $display("test %0d %s: %0d transfers, %0d errors", num, name, xfer_count,
             err_count - err_before);
  endtask

  initial begin
    rst_n         = 1'b0;
    fetch_rdy     = 1'b0;
    branch        = 1'b0;
    branch_target = '0;
    regwr_en      = 1'b0;
    regwr_sel     = '0;
    regwr_data    = '0;
    ack_delay     = 3'd0;
    rng           = 32'hf71d;
    checks        = 0;
    err_count     = 0;
    run_test(1, "sequential", 1'b0, 1'b0, 1'b0, 1'b0);
    run_test(2, "back-pressure", 1'b1, 1'b0, 1'b0, 1'b0);
    run_test(3, "memory stalls", 1'b1, 1'b1, 1'b0, 1'b0);
    run_test(4, "branch redirect", 1'b1, 1'b1, 1'b1, 1'b0);
    run_test(5, "register reads", 1'b1, 1'b1, 1'b0, 1'b1);
    fail_total = err_count + int'(dut0.u_props.fail_count);
    $display("checks %0d, errors %0d, assertion failures %0d", checks, err_count,
             dut0.u_props.fail_count);
    if (fail_total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, transfers stopped", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_stage_properties.sv
////////////////////////////////////////////////////////////
// handshake properties, bound into every fetch_stage
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_stage_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  instr_req,
  input logic                  instr_ack,
  input fetch_pkg::addr_t      instr_addr,
  input fetch_pkg::fetch_out_t fetch,
  input logic                  fetch_vld,
  input logic                  fetch_rdy,
  input logic                  branch
);

  // failures seen so far, read by the testbench at the end
  int unsigned fail_count;

  initial fail_count = 0;

  // a branch may move the address of a pending request
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req && !instr_ack && !branch |=> $stable(instr_addr))
    else begin
      $error("instr_addr changed while a request was pending");
      fail_count++;
    end

  fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_vld && !fetch_rdy && !branch |=> fetch_vld && $stable(fetch))
    else begin
      $error("fetch changed while decode was stalled");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !instr_req && !fetch_vld)
    else begin
      $error("instr_req or fetch_vld high right after reset");
      fail_count++;
    end

endmodule

bind fetch_stage fetch_stage_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .instr_req (instr_req),
  .instr_ack (instr_ack),
  .instr_addr(instr_addr),
  .fetch     (fetch),
  .fetch_vld (fetch_vld),
  .fetch_rdy (fetch_rdy),
  .branch    (branch)
);

`default_nettype wire

//--- fetch_imem_model.sv
////////////////////////////////////////////////////////////
// instruction memory model, data is a hash of the address;
// ack comes ack_delay idle cycles after the request opens
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_imem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_req,
  input  fetch_pkg::addr_t instr_addr,
  input  logic [2:0]       ack_delay,
  output logic             instr_ack,
  output fetch_pkg::word_t instr_data
);

  // cycles the current request has been pending
  logic [2:0] waited;
  logic [2:0] delay_q;
  logic [2:0] delay;

  function automatic fetch_pkg::word_t word_at(input fetch_pkg::addr_t addr);
    logic [31:0] x;
    x = addr ^ 32'h6a09_e667;
    x = x * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    x = x * 32'h85eb_ca6b;
    x = x ^ (x >> 13);
    return x;
  endfunction

  // delay is taken in the first request cycle and then held
  assign delay      = (waited == 3'd0) ? ack_delay : delay_q;
  assign instr_ack  = instr_req && (waited == delay);
  assign instr_data = instr_ack ? word_at(instr_addr) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      waited  <= 3'd0;
      delay_q <= 3'd0;
    end else if (!instr_req || instr_ack) begin
      waited <= 3'd0;
    end else begin
      waited <= waited + 3'd1;
      if (waited == 3'd0) begin
        delay_q <= ack_delay;
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch_stage.sv
////////////////////////////////////////////////////////////
// register reads follow the buffer head, valid with fetch_vld
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  output fetch_pkg::addr_t      instr_addr,
  output logic                  instr_req,
  input  fetch_pkg::word_t      instr_data,
  input  logic                  instr_ack,
  output fetch_pkg::fetch_out_t fetch,
  output logic                  fetch_vld,
  input  logic                  fetch_rdy,
  input  logic                  branch,
  input  fetch_pkg::addr_t      branch_target,
  output fetch_pkg::word_t      regrd_rs1,
  output fetch_pkg::word_t      regrd_rs2,
  input  logic                  regwr_en,
  input  fetch_pkg::reg_idx_t   regwr_sel,
  input  fetch_pkg::word_t      regwr_data
);

  logic                word_accept;
  logic                full;
  fetch_pkg::reg_idx_t rs1_sel;
  fetch_pkg::reg_idx_t rs2_sel;

  // rs fields of the instruction at the buffer head
  assign rs1_sel = fetch.ir[fetch_pkg::RS1_LSB +: fetch_pkg::REG_IDX_W];
  assign rs2_sel = fetch.ir[fetch_pkg::RS2_LSB +: fetch_pkg::REG_IDX_W];

  // the pc is the memory address
  fetch_pc u_pc (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch       (branch),
    .branch_target(branch_target),
    .word_accept  (word_accept),
    .pc           (instr_addr)
  );

  fetch_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .branch     (branch),
    .full       (full),
    .instr_ack  (instr_ack),
    .instr_req  (instr_req),
    .word_accept(word_accept)
  );

  fetch_buffer u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .branch     (branch),
    .word_accept(word_accept),
    .pc         (instr_addr),
    .instr_data (instr_data),
    .fetch      (fetch),
    .fetch_vld  (fetch_vld),
    .fetch_rdy  (fetch_rdy),
    .full       (full)
  );

  fetch_regfile u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1_sel   (rs1_sel),
    .rs2_sel   (rs2_sel),
    .rs1_data  (regrd_rs1),
    .rs2_data  (regrd_rs2),
    .regwr_en  (regwr_en),
    .regwr_sel (regwr_sel),
    .regwr_data(regwr_data)
  );

endmodule

`default_nettype wire

//--- fetch_regfile.sv
////////////////////////////////////////////////////////////
// no write-to-read bypass; a write shows one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_regfile (
  input  logic                clk,
  input  logic                rst_n,
  input  fetch_pkg::reg_idx_t rs1_sel,
  input  fetch_pkg::reg_idx_t rs2_sel,
  output fetch_pkg::word_t    rs1_data,
  output fetch_pkg::word_t    rs2_data,
  input  logic                regwr_en,
  input  fetch_pkg::reg_idx_t regwr_sel,
  input  fetch_pkg::word_t    regwr_data
);

  fetch_pkg::word_t regs [fetch_pkg::REG_COUNT];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < fetch_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regwr_en && (regwr_sel != '0)) begin
      regs[regwr_sel] <= regwr_data;
    end
  end

  // combinational reads, x0 forced to zero
  always_comb begin
    if (rs1_sel == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_sel];
    end
  end

  always_comb begin
    if (rs2_sel == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_sel];
    end
  end

endmodule

`default_nettype wire

//--- fetch_buffer.sv
////////////////////////////////////////////////////////////
// two entries; a write while full is never issued by
// the controller, so it is not checked here
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch,
  input  logic                  word_accept,
  input  fetch_pkg::addr_t      pc,
  input  fetch_pkg::word_t      instr_data,
  output fetch_pkg::fetch_out_t fetch,
  output logic                  fetch_vld,
  input  logic                  fetch_rdy,
  output logic                  full
);

  // head drives decode directly, tail is the second slot
  fetch_pkg::fetch_out_t head_q;
  fetch_pkg::fetch_out_t tail_q;
  fetch_pkg::fetch_out_t new_entry;
  logic                  head_vld;
  logic                  tail_vld;
  logic                  pop;

  assign new_entry = '{pc: pc, ir: instr_data};
  assign pop       = head_vld && fetch_rdy;

  // occupancy flags
  always_ff @(posedge clk) begin
    if (!rst_n || branch) begin
      head_vld <= 1'b0;
      tail_vld <= 1'b0;
    end else if (pop && !word_accept) begin
      head_vld <= tail_vld;
      tail_vld <= 1'b0;
    end else if (word_accept && !pop) begin
      head_vld <= 1'b1;
      tail_vld <= head_vld;
    end
  end

  // payload moves without reset
  always_ff @(posedge clk) begin
    if (pop) begin
      if (tail_vld) begin
        head_q <= tail_q;
        tail_q <= new_entry;
      end else begin
        head_q <= new_entry;
      end
    end else if (word_accept) begin
      if (head_vld) begin
        tail_q <= new_entry;
      end else begin
        head_q <= new_entry;
      end
    end
  end

  assign fetch     = head_q;
  assign fetch_vld = head_vld;
  assign full      = tail_vld;

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
////////////////////////////////////////////////////////////
// one outstanding request at a time; no request starts
// while the buffer is full or a branch is present
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic branch,
  input  logic full,
  input  logic instr_ack,
  output logic instr_req,
  output logic word_accept
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;

  always_comb begin
    state_d     = state_q;
    word_accept = 1'b0;

    case (state_q)
      fetch_pkg::IDLE: begin
        if (!full && !branch) begin
          state_d = fetch_pkg::WAIT_ACK;
        end
      end

      fetch_pkg::WAIT_ACK: begin
        if (branch) begin
          // ack together with branch ends the request right away
          state_d = instr_ack ? fetch_pkg::IDLE : fetch_pkg::DISCARD;
        end else if (instr_ack) begin
          state_d     = fetch_pkg::IDLE;
          word_accept = 1'b1;
        end
      end

      fetch_pkg::DISCARD: begin
        // stale word, wait for it but never keep it
        if (instr_ack) begin
          state_d = fetch_pkg::IDLE;
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request held until the ack cycle, also for a stale word
  assign instr_req = (state_q == fetch_pkg::WAIT_ACK) ||
                     (state_q == fetch_pkg::DISCARD);

endmodule

`default_nettype wire

//--- fetch_pc.sv
////////////////////////////////////////////////////////////
// a branch moves pc, and so instr_addr, even while a
// request is pending; the word then in flight is dropped
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fetch_pc (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            branch,
  input  fetch_pkg::addr_t branch_target,
  input  logic            word_accept,
  output fetch_pkg::addr_t pc
);

  fetch_pkg::addr_t pc_next;

  // branch wins over a word accepted in the same cycle
  always_comb begin
    pc_next = pc;
    if (branch) begin
      pc_next = branch_target;
    end else if (word_accept) begin
      pc_next = pc + fetch_pkg::PC_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= fetch_pkg::RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
////////////////////////////////////////////////////////////
// RV32 fetch stage types; all widths fixed by the ISA
////////////////////////////////////////////////////////////

`default_nettype none

package fetch_pkg;

  // data and address width
  localparam int XLEN = 32;

  // register file geometry
  localparam int REG_IDX_W = 5;
  localparam int REG_COUNT = 32;

  // rs field positions inside an instruction word
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;

  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // pc after reset
  localparam addr_t RESET_PC = 32'h0000_0000;

  // one uncompressed instruction per step
  localparam addr_t PC_STEP = 32'd4;

  // fetch controller states
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    WAIT_ACK = 2'd1,
    DISCARD  = 2'd2
  } fetch_state_e;

  // payload toward decode, also the buffer entry
  typedef struct packed {
    addr_t pc;
    word_t ir;
  } fetch_out_t;

endpackage

`default_nettype wire
